/* aes_golden.hex */
// header: cmd | skip_key | blk_cnt | input word count, 32 bits each
// then input buffer words, then expected output blocks, all in wire form
// fips-197 appendix b, ecb single block
00000000000000000000000100000002
16157e2ba6d2ae288815f7ab3c4fcf09
a8f643328d305a88a2983131340737e0
1d842539fb09dc02978511dc320b6a19
// sp 800-38a ecb, fifth block repeats the first
00000000000000000000000500000006
16157e2ba6d2ae288815f7ab3c4fcf09
e2bec16b969f402e117e3de92a179373
578a2dae9cac031eac6fb79e518eaf45
461cc83011e45ca319c1fbe5ef520a1a
45249ff6179b4fdf7b412bad10376ce6
e2bec16b969f402e117e3de92a179373
b47bd73a60367a0df3ca9ea897ef6624
85d5d3f59d69b9035a8985e7afbafd96
7fcdb14323ce8e59e3001b88880603ed
5e780c7b3fade82771202382d45d7204
b47bd73a60367a0df3ca9ea897ef6624
// sp 800-38a cbc, four blocks
00000001000000000000000400000006
16157e2ba6d2ae288815f7ab3c4fcf09
03020100070605040b0a09080f0e0d0c
e2bec16b969f402e117e3de92a179373
578a2dae9cac031eac6fb79e518eaf45
461cc83011e45ca319c1fbe5ef520a1a
45249ff6179b4fdf7b412bad10376ce6
acab497646b219819b8ee9ce7d19e912
9bcb8650ee1972503a11db95b2787691
b8d6be733b74c1e39ee6167116952222
a1caf13f09ac1f6830ca0e12a7e18675
// same cbc message, first half
00000001000000000000000200000004
16157e2ba6d2ae288815f7ab3c4fcf09
03020100070605040b0a09080f0e0d0c
e2bec16b969f402e117e3de92a179373
578a2dae9cac031eac6fb79e518eaf45
acab497646b219819b8ee9ce7d19e912
9bcb8650ee1972503a11db95b2787691
// second half with skip_key
00000001000000010000000200000002
461cc83011e45ca319c1fbe5ef520a1a
45249ff6179b4fdf7b412bad10376ce6
b8d6be733b74c1e39ee6167116952222
a1caf13f09ac1f6830ca0e12a7e18675
// end of records
00000000000000000000000000000000

/* project.f */
aes_pkg.sv
aes_cmd_decode.sv
aes_key_step.sv
aes_round_core.sv
aes_chain_writer.sv
aes_controller.sv
aes_subsystem.sv
tb_aes_subsystem.sv

/* Bender.yml */
package:
  name: aes_subsystem

sources:
  - aes_pkg.sv
  - aes_cmd_decode.sv
  - aes_key_step.sv
  - aes_round_core.sv
  - aes_chain_writer.sv
  - aes_controller.sv
  - aes_subsystem.sv
  - target: test
    files:
      - tb_aes_subsystem.sv

/* tb_aes_subsystem.sv */
`timescale 1ns/100ps

module tb_aes_subsystem import aes_pkg::*; ();

        localparam int gold_depth = 128;
        localparam int buf_depth = 1 << buf_aw;
        localparam int ack_limit = 4000;
        localparam int release_limit = 20;

        logic clk;
        logic reset;
        logic start_req;
        logic start_ack;
        logic [cmd_w-1:0] cmd;
        logic [buf_aw-1:0] blk_cnt;
        logic skip_key;
        logic in_rd_en;
        logic [buf_aw-1:0] in_rd_addr;
        logic [blk_w-1:0] in_rd_data;
        logic out_wr_en;
        logic [buf_aw-1:0] out_wr_addr;
        logic [blk_w-1:0] out_wr_data;

        logic [blk_w-1:0] gold [0:gold_depth-1];
        logic [blk_w-1:0] in_mem [0:buf_depth-1];
        logic [blk_w-1:0] out_mem [0:buf_depth-1];

        int errors;
        int checks;
        int wr_count;
        int rd_count;
        bit job_active;
        bit timed_out;

        aes_subsystem dut0 (
                .clk(clk),
                .reset(reset),
                .start_req(start_req),
                .start_ack(start_ack),
                .cmd(cmd),
                .blk_cnt(blk_cnt),
                .skip_key(skip_key),
                .in_rd_en(in_rd_en),
                .in_rd_addr(in_rd_addr),
                .in_rd_data(in_rd_data),
                .out_wr_en(out_wr_en),
                .out_wr_addr(out_wr_addr),
                .out_wr_data(out_wr_data)
        );

        always #4 clk = ~clk;

        // input buffer answers one cycle after the read strobe
        // key, iv and payload words are read once each, in address order
        always @(posedge clk) begin
                if (in_rd_en) begin
                        checks++;
                        assert (job_active) else begin
                                $display("input buffer read while no job was running");
                                errors++;
                        end
                        checks++;
                        assert (in_rd_addr == rd_count[buf_aw-1:0]) else begin
                                $display("Mismatch in_rd_addr: expected %h, got %h",
                                        rd_count[buf_aw-1:0], in_rd_addr);
                                errors++;
                        end
                        in_rd_data <= in_mem[in_rd_addr];
                        rd_count++;
                end
        end

        // output buffer capture
        always @(posedge clk) begin
                if (out_wr_en) begin
                        checks++;
                        assert (job_active && out_wr_addr < blk_cnt) else begin
                                $display("write to address %h outside the current job",
                                        out_wr_addr);
                                errors++;
                        end
                        out_mem[out_wr_addr] = out_wr_data;
                        wr_count++;
                end
        end

        task automatic wait_ack_level(input logic level, input int limit, output bit ok);
                int n;
                ok = 1'b0;
                n = 0;
                while (!ok && n < limit) begin
                        @(negedge clk);
                        if (start_ack === level)
                                ok = 1'b1;
                        n++;
                end
        endtask

        task automatic run_job(input int p, input int job, output int next_p);
                logic [blk_w-1:0] hdr;
                int n_in;
                int n_blk;
                int first_err;
                int hold;
                bit ok;
                hdr = gold[p];
                n_blk = hdr[63:32];
                n_in = hdr[31:0];
                first_err = errors;
                next_p = p + 1 + n_in + n_blk;
                for (int a = 0; a < buf_depth; a++) begin
                        in_mem[a] = (a < n_in) ? gold[p + 1 + a] : {4{7'h55, a[8:0], 16'hc3a5}};
                        out_mem[a] = 'x;
                end
                wr_count = 0;
                rd_count = 0;

                @(posedge clk);
                cmd <= hdr[96 +: cmd_w];
                skip_key <= hdr[64];
                blk_cnt <= n_blk[buf_aw-1:0];
                start_req <= 1'b1;
                job_active = 1'b1;

                wait_ack_level(1'b1, ack_limit, ok);
                if (!ok) begin
                        $display("timeout: start_ack never rose in job %0d", job);
                        timed_out = 1'b1;
                end else begin
                        // ack has to stay up while the host holds req
                        hold = $urandom % 6;
                        repeat (hold) begin
                                @(negedge clk);
                                checks++;
                                assert (start_ack === 1'b1) else begin
                                        $display("start_ack dropped while start_req was high");
                                        errors++;
                                end
                        end
                        @(posedge clk);
                        start_req <= 1'b0;
                        @(negedge clk);
                        checks++;
                        assert (start_ack === 1'b1) else begin
                                $display("start_ack fell in the same cycle as start_req");
                                errors++;
                        end
                        wait_ack_level(1'b0, release_limit, ok);
                        if (!ok) begin
                                $display("timeout: start_ack never fell in job %0d", job);
                                timed_out = 1'b1;
                        end
                end

                if (!timed_out) begin
                        job_active = 1'b0;
                        checks++;
                        assert (wr_count == n_blk) else begin
                                $display("Mismatch write count: expected %h, got %h",
                                        n_blk, wr_count);
                                errors++;
                        end
                        checks++;
                        assert (rd_count == n_in) else begin
                                $display("Mismatch read count: expected %h, got %h",
                                        n_in, rd_count);
                                errors++;
                        end
                        for (int k = 0; k < n_blk; k++) begin
                                checks++;
                                assert (out_mem[k] === gold[p + 1 + n_in + k]) else begin
                                        $display("Mismatch out_wr_data[%h]: expected %h, got %h",
                                                k[buf_aw-1:0], gold[p + 1 + n_in + k], out_mem[k]);
                                        errors++;
                                end
                        end
                        $display("job %0d: cmd %0d, skip_key %0d, %0d blocks, %0d errors",
                                job, hdr[96 +: cmd_w], hdr[64], n_blk, errors - first_err);
                end
        endtask

        initial begin
                int p;
                int next_p;
                int job;
                int reset_err;
                bit more;
                void'($urandom(85));
                clk = 1'b0;
                reset = 1'b1;
                start_req = 1'b0;
                cmd = '0;
                blk_cnt = '0;
                skip_key = 1'b0;
                in_rd_data = '0;
                errors = 0;
                checks = 0;
                wr_count = 0;
                rd_count = 0;
                job_active = 1'b0;
                timed_out = 1'b0;
                $readmemh("aes_golden.hex", gold);

                repeat (10) @(posedge clk);
                reset <= 1'b0;

                // idle after reset
                reset_err = errors;
                repeat (6) begin
                        @(negedge clk);
                        checks++;
                        assert (start_ack === 1'b0 && out_wr_en === 1'b0 && in_rd_en === 1'b0)
                        else begin
                                $display("DUT not idle after reset with no job started");
                                errors++;
                        end
                end
                $display("reset: %0d errors", errors - reset_err);

                // header of all zeros ends the record list
                p = 0;
                job = 1;
                more = 1'b1;
                while (more && !timed_out) begin
                        if (p >= gold_depth || $isunknown(gold[p]) || gold[p] == '0) begin
                                more = 1'b0;
                        end else begin
                                repeat ($urandom % 6) @(posedge clk);
                                run_job(p, job, next_p);
                                p = next_p;
                                job++;
                        end
                end

                if (job == 1)
                        $display("no job records were read from aes_golden.hex");
                $display("jobs %0d, checks %0d, errors %0d", job - 1, checks, errors);
                if (timed_out || errors != 0 || job == 1) begin
                        $display("Simulation failed");
                end else begin
                        $display("Simulation passed");
                end
                $finish;
        end

endmodule

/* aes_subsystem.sv */
`timescale 1ns/100ps

module aes_subsystem import aes_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  logic start_req,
        output logic start_ack,
        input  logic [cmd_w-1:0] cmd,
        input  logic [buf_aw-1:0] blk_cnt,
        input  logic skip_key,
        output logic in_rd_en,
        output logic [buf_aw-1:0] in_rd_addr,
        input  logic [blk_w-1:0] in_rd_data,
        output logic out_wr_en,
        output logic [buf_aw-1:0] out_wr_addr,
        output logic [blk_w-1:0] out_wr_data
);

        logic latch;
        logic is_cbc;
        logic need_key;
        logic need_iv;
        logic core_req;
        logic core_ack;
        logic key_load;
        logic [blk_w-1:0] key_in;
        logic [blk_w-1:0] core_in;
        logic [blk_w-1:0] core_out;
        logic blk_done;
        logic job_start;

        aes_cmd_decode decode0 (
                .clk(clk),
                .reset(reset),
                .start_req(start_req),
                .cmd(cmd),
                .skip_key(skip_key),
                .latch(latch),
                .is_cbc(is_cbc),
                .need_key(need_key),
                .need_iv(need_iv)
        );

        aes_controller ctrl0 (
                .clk(clk),
                .reset(reset),
                .start_req(start_req),
                .start_ack(start_ack),
                .blk_cnt(blk_cnt),
                .latch(latch),
                .is_cbc(is_cbc),
                .need_key(need_key),
                .need_iv(need_iv),
                .in_rd_en(in_rd_en),
                .in_rd_addr(in_rd_addr),
                .in_rd_data(in_rd_data),
                .core_req(core_req),
                .core_ack(core_ack),
                .key_load(key_load),
                .key_in(key_in),
                .core_in(core_in),
                .core_out(core_out),
                .blk_done(blk_done),
                .job_start(job_start)
        );

        aes_round_core core0 (
                .clk(clk),
                .reset(reset),
                .core_req(core_req),
                .core_ack(core_ack),
                .key_load(key_load),
                .key_in(key_in),
                .core_in(core_in),
                .core_out(core_out)
        );

        aes_chain_writer writer0 (
                .clk(clk),
                .reset(reset),
                .blk_done(blk_done),
                .cipher_blk(core_out),
                .job_start(job_start),
                .out_wr_en(out_wr_en),
                .out_wr_addr(out_wr_addr),
                .out_wr_data(out_wr_data)
        );

endmodule

/* aes_controller.sv */
`timescale 1ns/100ps

module aes_controller import aes_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  logic start_req,
        output logic start_ack,
        input  logic [buf_aw-1:0] blk_cnt,
        output logic latch,
        input  logic is_cbc,
        input  logic need_key,
        input  logic need_iv,
        output logic in_rd_en,
        output logic [buf_aw-1:0] in_rd_addr,
        input  logic [blk_w-1:0] in_rd_data,
        output logic core_req,
        input  logic core_ack,
        output logic key_load,
        output logic [blk_w-1:0] key_in,
        output logic [blk_w-1:0] core_in,
        input  logic [blk_w-1:0] core_out,
        output logic blk_done,
        output logic job_start
);

        logic [2:0] state;
        logic [buf_aw-1:0] rd_ptr;
        logic [buf_aw-1:0] blk_n;
        logic rd_v;
        logic [blk_w-1:0] rd_blk;
        logic [blk_w-1:0] chain;

        assign rd_blk = swap_words(in_rd_data);
        assign in_rd_addr = rd_ptr;
        assign latch = (state == s_idle) && start_req;
        assign job_start = (state == s_idle) && start_req;
        assign blk_done = (state == s_wait) && core_ack;

        // one read in flight, consumed on the cycle rd_v is high
        assign in_rd_en = !rd_v && ((state == s_key && need_key) ||
                (state == s_iv && need_iv) || state == s_issue);

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= s_idle;
                        rd_ptr <= '0;
                        blk_n <= '0;
                        rd_v <= 1'b0;
                        core_req <= 1'b0;
                        key_load <= 1'b0;
                        start_ack <= 1'b0;
                end else begin
                        rd_v <= in_rd_en;
                        case (state)
                                s_idle: begin
                                        if (start_req) begin
                                                rd_ptr <= '0;
                                                blk_n <= '0;
                                                state <= s_key;
                                        end
                                end
                                s_key: begin
                                        if (!need_key) begin
                                                state <= s_iv;
                                        end else if (rd_v) begin
                                                key_load <= 1'b1;
                                                rd_ptr <= rd_ptr + 1'b1;
                                                state <= s_iv;
                                        end
                                end
                                s_iv: begin
                                        if (!need_iv) begin
                                                state <= s_issue;
                                        end else if (rd_v) begin
                                                rd_ptr <= rd_ptr + 1'b1;
                                                state <= s_issue;
                                        end
                                end
                                s_issue: begin
                                        if (rd_v) begin
                                                core_req <= 1'b1;
                                                rd_ptr <= rd_ptr + 1'b1;
                                                state <= s_wait;
                                        end
                                end
                                s_wait: begin
                                        if (core_ack) begin
                                                // core now holds the key
                                                key_load <= 1'b0;
                                                core_req <= 1'b0;
                                                blk_n <= blk_n + 1'b1;
                                                state <= s_release;
                                        end
                                end
                                s_release: begin
                                        if (!core_ack) begin
                                                if (blk_n == blk_cnt) begin
                                                        start_ack <= 1'b1;
                                                        state <= s_done;
                                                end else begin
                                                        state <= s_issue;
                                                end
                                        end
                                end
                                s_done: begin
                                        if (!start_req) begin
                                                start_ack <= 1'b0;
                                                state <= s_idle;
                                        end
                                end
                                default: state <= s_idle;
                        endcase
                end
        end

        // chain value survives skip_key jobs
        always_ff @(posedge clk) begin
                if (state == s_key && need_key && rd_v)
                        key_in <= rd_blk;
                if (state == s_iv && need_iv && rd_v)
                        chain <= rd_blk;
                else if (blk_done)
                        chain <= core_out;
                if (state == s_issue && rd_v)
                        core_in <= is_cbc ? (rd_blk ^ chain) : rd_blk;
        end

endmodule

/* aes_chain_writer.sv */
`timescale 1ns/100ps

module aes_chain_writer import aes_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  logic blk_done,
        input  logic [blk_w-1:0] cipher_blk,
        input  logic job_start,
        output logic out_wr_en,
        output logic [buf_aw-1:0] out_wr_addr,
        output logic [blk_w-1:0] out_wr_data
);

        logic [buf_aw-1:0] wr_ptr;

        always_ff @(posedge clk) begin
                if (reset) begin
                        out_wr_en <= 1'b0;
                        wr_ptr <= '0;
                end else begin
                        out_wr_en <= blk_done;
                        // output block k lands at address k of each job
                        if (job_start)
                                wr_ptr <= '0;
                        else if (blk_done)
                                wr_ptr <= wr_ptr + 1'b1;
                end
        end

        // back to wire form on the way out
        always_ff @(posedge clk) begin
                if (blk_done) begin
                        out_wr_addr <= wr_ptr;
                        out_wr_data <= swap_words(cipher_blk);
                end
        end

endmodule

/* aes_round_core.sv */
`timescale 1ns/100ps

module aes_round_core import aes_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  logic core_req,
        output logic core_ack,
        input  logic key_load,
        input  logic [blk_w-1:0] key_in,
        input  logic [blk_w-1:0] core_in,
        output logic [blk_w-1:0] core_out
);

        logic [1:0] fsm;
        logic [3:0] round;
        aes_state_t st;
        aes_state_t rk;
        aes_state_t key_q;
        aes_state_t k0;
        aes_state_t nxt_rk;
        aes_state_t sb;
        aes_state_t sr;
        aes_state_t mc;
        logic [7:0] rcon;
        logic [7:0] nxt_rcon;

        function automatic logic [31:0] mix_col(input logic [31:0] col);
                logic [7:0] a0;
                logic [7:0] a1;
                logic [7:0] a2;
                logic [7:0] a3;
                a0 = col[31:24];
                a1 = col[23:16];
                a2 = col[15:8];
                a3 = col[7:0];
                return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                        a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                        a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                        xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
        endfunction

        aes_key_step ks0 (
                .rk_in(rk),
                .rcon_in(rcon),
                .rk_out(nxt_rk),
                .rcon_out(nxt_rcon)
        );

        // new key only when the sequencer asks for it
        assign k0 = key_load ? key_in : key_q;
        assign core_out = st;

        always_comb begin
                for (int i = 0; i < 16; i++) begin
                        sb.b[i] = sbox(st.b[i]);
                end
                // row r rotates left by r columns
                for (int c = 0; c < 4; c++) begin
                        for (int r = 0; r < 4; r++) begin
                                sr.b[4*c + r] = sb.b[4*((c + r) % 4) + r];
                        end
                end
                // last round has no MixColumns
                for (int c = 0; c < 4; c++) begin
                        mc.c[c] = (round == n_rounds) ? sr.c[c] : mix_col(sr.c[c]);
                end
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        fsm <= cs_idle;
                        core_ack <= 1'b0;
                        round <= 4'd0;
                end else begin
                        case (fsm)
                                cs_idle: begin
                                        if (core_req) begin
                                                round <= 4'd1;
                                                fsm <= cs_run;
                                        end
                                end
                                cs_run: begin
                                        round <= round + 4'd1;
                                        if (round == n_rounds) begin
                                                core_ack <= 1'b1;
                                                fsm <= cs_ack;
                                        end
                                end
                                cs_ack: begin
                                        if (!core_req) begin
                                                core_ack <= 1'b0;
                                                fsm <= cs_idle;
                                        end
                                end
                                default: fsm <= cs_idle;
                        endcase
                end
        end

        always_ff @(posedge clk) begin
                if (fsm == cs_idle && core_req) begin
                        // initial AddRoundKey
                        key_q <= k0;
                        rk <= k0;
                        rcon <= 8'h01;
                        st <= core_in ^ k0;
                end else if (fsm == cs_run) begin
                        rk <= nxt_rk;
                        rcon <= nxt_rcon;
                        for (int c = 0; c < 4; c++) begin
                                st.c[c] <= mc.c[c] ^ nxt_rk.c[c];
                        end
                end
        end

endmodule

/* aes_key_step.sv */
`timescale 1ns/100ps

module aes_key_step import aes_pkg::*; (
        input  aes_state_t rk_in,
        input  logic [7:0] rcon_in,
        output aes_state_t rk_out,
        output logic [7:0] rcon_out
);

        logic [word_w-1:0] rot;
        logic [word_w-1:0] subw;
        logic [word_w-1:0] temp;

        always_comb begin
                // RotWord on the last column
                rot = {rk_in.c[3][23:0], rk_in.c[3][31:24]};
                for (int i = 0; i < 4; i++) begin
                        subw[i*8 +: 8] = sbox(rot[i*8 +: 8]);
                end
                temp = subw ^ {rcon_in, 24'h000000};

                // each column chains off the one before
                rk_out.c[0] = rk_in.c[0] ^ temp;
                for (int j = 1; j < 4; j++) begin
                        rk_out.c[j] = rk_out.c[j-1] ^ rk_in.c[j];
                end
        end

        // 01, 02, 04 .. 80, 1b, 36
        assign rcon_out = xtime(rcon_in);

endmodule

/* aes_cmd_decode.sv */
`timescale 1ns/100ps

module aes_cmd_decode import aes_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  logic start_req,
        input  logic [cmd_w-1:0] cmd,
        input  logic skip_key,
        input  logic latch,
        output logic is_cbc,
        output logic need_key,
        output logic need_iv
);

        logic cbc_q;
        logic skip_q;

        // held for the whole job, host may change cmd after ack
        always_ff @(posedge clk) begin
                if (reset) begin
                        cbc_q <= 1'b0;
                        skip_q <= 1'b0;
                end else if (latch && start_req) begin
                        skip_q <= skip_key;
                        case (cmd)
                                cmd_cbc_enc: cbc_q <= 1'b1;
                                cmd_ecb_enc: cbc_q <= 1'b0;
                                default: cbc_q <= 1'b0;
                        endcase
                end
        end

        assign is_cbc = cbc_q;
        assign need_key = !skip_q;
        // continuation jobs keep the running chain value
        assign need_iv = cbc_q && !skip_q;

endmodule

/* aes_pkg.sv */
package aes_pkg;

        localparam int blk_w = 128;
        localparam int word_w = 32;
        localparam int buf_aw = 9;
        localparam int cmd_w = 2;
        localparam int n_rounds = 10;

        // host command codes, anything else runs as ecb
        localparam logic [cmd_w-1:0] cmd_ecb_enc = 2'd0;
        localparam logic [cmd_w-1:0] cmd_cbc_enc = 2'd1;

        // cipher core fsm
        localparam logic [1:0] cs_idle = 2'd0;
        localparam logic [1:0] cs_run = 2'd1;
        localparam logic [1:0] cs_ack = 2'd2;

        // job sequencer fsm
        localparam logic [2:0] s_idle = 3'd0;
        localparam logic [2:0] s_key = 3'd1;
        localparam logic [2:0] s_iv = 3'd2;
        localparam logic [2:0] s_issue = 3'd3;
        localparam logic [2:0] s_wait = 3'd4;
        localparam logic [2:0] s_release = 3'd5;
        localparam logic [2:0] s_done = 3'd6;

        // byte 0 is the most significant byte, column 0 the most significant word
        typedef union packed {
                logic [0:15][7:0] b;
                logic [0:3][word_w-1:0] c;
        } aes_state_t;

        function automatic logic [7:0] xtime(input logic [7:0] a);
                return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
        endfunction

        function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
                logic [7:0] p;
                logic [7:0] t;
                p = 8'h00;
                t = a;
                for (int i = 0; i < 8; i++) begin
                        if (b[i])
                                p = p ^ t;
                        t = xtime(t);
                end
                return p;
        endfunction

        function automatic logic [7:0] sbox(input logic [7:0] a);
                logic [7:0] sq;
                logic [7:0] inv;
                sq = a;
                inv = 8'h01;
                // a^254 built from a^2 .. a^128, gives 0 for a = 0
                for (int i = 1; i < 8; i++) begin
                        sq = gf_mul(sq, sq);
                        inv = gf_mul(inv, sq);
                end
                // affine map
                return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                        ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
        endfunction

        // buffer words carry each 32-bit word byte reversed
        function automatic logic [blk_w-1:0] swap_words(input logic [blk_w-1:0] blk);
                logic [blk_w-1:0] s;
                for (int w = 0; w < blk_w / word_w; w++) begin
                        for (int i = 0; i < word_w / 8; i++) begin
                                s[w*word_w + i*8 +: 8] = blk[w*word_w + (word_w/8 - 1 - i)*8 +: 8];
                        end
                end
                return s;
        endfunction

endpackage
